// File: tb/beep_tests.txt
// key, note count, hold cycles into the next note before release,
// then 30 expected pwm periods in clock cycles, 0 = silent
// key 111, nothing held
7 2 0
0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
// key 101, whole song
5 1c 0
4fb 4fb 470 4fb 778 3f4 0
4fb 4fb 470 4fb 6a7 778 0
4fb 4fb 4fb 5ed 778 3f4 470
598 598 5ed 778 6a7 778 0
0 0
// key 101, released 5000 cycles into note 3
5 3 1388
4fb 4fb 470 4fb 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
// key 101, wraps back to SO SO after note 28
5 1e 0
4fb 4fb 470 4fb 778 3f4 0
4fb 4fb 470 4fb 6a7 778 0
4fb 4fb 4fb 5ed 778 3f4 470
598 598 5ed 778 6a7 778 0
4fb 4fb
// key 110
6 2 0
0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
// key 011
3 2 0
0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
// key 000
0 2 0
0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0
// end of records
ffff

// File: project.f
rtl/beep_note_pkg.sv
rtl/beep_timing_pkg.sv
rtl/note_timer.sv
rtl/score_sequencer.sv
rtl/tone_gen.sv
rtl/beep_top.sv
tb/tb_clk_gen.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
# build with Verilator and run from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_top -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import beep_note_pkg::*;
();

    localparam int CLK_HZ     = 1_000_000;
    localparam int NOTE_TICKS = 20_000;
    localparam int GAP_K      = NOTE_TICKS - NOTE_TICKS / 8;  // last eighth is silent
    localparam int GUARD      = 8;      // pipeline settles at note edges
    localparam int REC_LEN    = 33;     // key, notes, hold, 30 periods
    localparam int MAX_TESTS  = 8;

    logic        clk;
    logic        rst_n;
    key_t        key;
    logic        pwm;
    logic        pwm_prev;
    logic [15:0] tests_mem [0:REC_LEN*MAX_TESTS-1];
    int          gaps [0:MAX_TESTS-1];
    int          n_tests;
    int          test_errs;
    int          total_errs;
    int          failed_tests;
    longint      limit_ns;
    integer      seed = 39;

    tb_clk_gen #(
        .HALF_NS      (5),
        .RESET_CYCLES (16)
    ) i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    beep_top #(
        .CLK_HZ     (CLK_HZ),
        .NOTE_TICKS (NOTE_TICKS)
    ) i_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .key   (key),
        .pwm   (pwm)
    );

    task automatic value_fail(input string sig, input int got, input int exp);
        test_errs++;
        $display("Fail %0t %s got %0d expected %0d", $time, sig, got, exp);
    endtask

    task automatic note_fail(input string what);
        test_errs++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // one note window, sampled on the falling clock edge
    task automatic check_slot(input int exp_period, input int cycles, input int slot);
        int k;
        int last_fall;
        int low_start;
        int falls;
        bit reported;
        last_fall = -1;
        low_start = -1;
        falls     = 0;
        reported  = 1'b0;
        for (k = 0; k < cycles; k++) begin
            @(negedge clk);
            if (exp_period == 0 || k >= GAP_K + GUARD) begin
                // rest or release gap
                if (k >= GUARD && pwm !== 1'b1 && !reported) begin
                    value_fail("pwm", int'(pwm), 1);
                    reported = 1'b1;
                end
            end else if (k >= GUARD && k < GAP_K) begin
                if (pwm_prev === 1'b1 && pwm === 1'b0) begin
                    if (last_fall >= 0 && k - last_fall != exp_period) begin
                        value_fail("pwm_period", k - last_fall, exp_period);
                    end
                    last_fall = k;
                    low_start = k;
                    falls++;
                end else if (pwm_prev === 1'b0 && pwm === 1'b1 && low_start >= 0) begin
                    if (k - low_start != exp_period / 16) begin
                        value_fail("pwm_low_width", k - low_start, exp_period / 16);
                    end
                    low_start = -1;
                end
            end
            pwm_prev = pwm;
        end
        if (exp_period != 0 && cycles >= GUARD + 2 * exp_period && falls < 2) begin
            note_fail($sformatf("note slot %0d gave no tone on pwm", slot));
        end
    endtask

    // key released, pwm must go quiet
    task automatic idle_check(input int cycles);
        int k;
        bit reported;
        reported = 1'b0;
        for (k = 0; k < cycles; k++) begin
            @(negedge clk);
            if (k >= GUARD && pwm !== 1'b1 && !reported) begin
                value_fail("pwm", int'(pwm), 1);
                reported = 1'b1;
            end
            pwm_prev = pwm;
        end
    endtask

    task automatic finish_test(input string name, input int n_notes);
        if (test_errs == 0) begin
            $display("%s, %0d notes: ok", name, n_notes);
        end else begin
            $display("%s, %0d notes: %0d errors", name, n_notes, test_errs);
            failed_tests++;
        end
        total_errs += test_errs;
    endtask

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("watchdog: run still going after %0d ns, stopping", limit_ns);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int     base;
        int     t;
        int     s;
        int     n_notes;
        int     hold;
        longint total_cycles;
        key_t   pat;

        key <= 3'b111;
        pwm_prev     = 1'b1;
        limit_ns     = 0;
        total_errs   = 0;
        failed_tests = 0;
        n_tests      = 0;

        $readmemh("tb/beep_tests.txt", tests_mem);
        while (n_tests < MAX_TESTS && tests_mem[n_tests*REC_LEN] != 16'hffff) begin
            n_tests++;
        end

        // idle gaps drawn up front so the watchdog knows the full length
        total_cycles = 16;
        for (t = 0; t < n_tests; t++) begin
            gaps[t] = 200 + int'($unsigned($random(seed)) % 800);
            total_cycles += longint'(tests_mem[t*REC_LEN+1]) * NOTE_TICKS;
            total_cycles += longint'(tests_mem[t*REC_LEN+2]) + gaps[t] + 2;
        end
        limit_ns = total_cycles * 15;   // 10 ns per cycle, plus half again

        test_errs = 0;
        if (n_tests == 0) begin
            note_fail("no test records found in tb/beep_tests.txt");
        end
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            if (pwm !== 1'b1) begin
                value_fail("pwm", int'(pwm), 1);
            end
            pwm_prev = pwm;
        end
        finish_test("reset, key 111", 0);

        for (t = 0; t < n_tests; t++) begin
            base      = t * REC_LEN;
            pat       = key_t'(tests_mem[base]);
            n_notes   = int'(tests_mem[base+1]);
            hold      = int'(tests_mem[base+2]);
            test_errs = 0;

            @(posedge clk);
            key <= pat;
            for (s = 0; s < n_notes; s++) begin
                check_slot(int'(tests_mem[base+3+s]), NOTE_TICKS, s);
            end
            if (hold > 0) begin
                check_slot(int'(tests_mem[base+3+n_notes]), hold, n_notes);  // cut mid-note
            end

            @(posedge clk);
            key <= 3'b111;
            idle_check(gaps[t]);
            finish_test($sformatf("test %0d, key %b", t + 1, pat), n_notes);
        end

        $display("%0d tests run, %0d failed, %0d errors", n_tests + 1, failed_tests,
                 total_errs);
        if (total_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_NS      = 5,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;   // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: rtl/beep_top.sv
`timescale 1ns/1ps
`default_nettype none

module beep_top
    import beep_note_pkg::*;
#(
    parameter int CLK_HZ     = 50_000_000,
    parameter int NOTE_TICKS = 15_000_000
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire key_t key,
    output logic      pwm
);

    logic  play;
    logic  note_end;
    logic  release_gap;
    note_t note;

    note_timer #(
        .NOTE_TICKS (NOTE_TICKS)
    ) i_note_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .play        (play),
        .note_end    (note_end),
        .release_gap (release_gap)
    );

    score_sequencer i_score_sequencer (
        .clk      (clk),
        .rst_n    (rst_n),
        .key      (key),
        .note_end (note_end),
        .play     (play),
        .note     (note)
    );

    tone_gen #(
        .CLK_HZ (CLK_HZ)
    ) i_tone_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .play        (play),
        .note        (note),
        .release_gap (release_gap),
        .pwm         (pwm)
    );

endmodule

`default_nettype wire

// File: rtl/tone_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tone_gen
    import beep_note_pkg::*, beep_timing_pkg::*;
#(
    parameter int CLK_HZ = 50_000_000
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  play,
    input  wire note_t note,
    input  wire logic  release_gap,
    output logic       pwm
);

    // clock cycles per pitch period
    localparam period_t P_DO = period_t'(CLK_HZ / FREQ_DO);
    localparam period_t P_RE = period_t'(CLK_HZ / FREQ_RE);
    localparam period_t P_MI = period_t'(CLK_HZ / FREQ_MI);
    localparam period_t P_FA = period_t'(CLK_HZ / FREQ_FA);
    localparam period_t P_SO = period_t'(CLK_HZ / FREQ_SO);
    localparam period_t P_LA = period_t'(CLK_HZ / FREQ_LA);
    localparam period_t P_SI = period_t'(CLK_HZ / FREQ_SI);

    period_t period;
    period_t per_cnt;
    note_t   note_q;
    logic    silent;

    always_comb begin
        case (note)
            DO:      period = P_DO;
            RE:      period = P_RE;
            MI:      period = P_MI;
            FA:      period = P_FA;
            SO:      period = P_SO;
            LA:      period = P_LA;
            SI:      period = P_SI;
            default: period = period_t'(1);     // rest, counter idles at 0
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            note_q  <= REST;
            per_cnt <= '0;
        end else begin
            note_q <= note;
            if (!play || note != note_q) begin
                per_cnt <= '0;      // new pitch starts a fresh period
            end else if (per_cnt >= period - 1'b1) begin
                per_cnt <= '0;
            end else begin
                per_cnt <= per_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            silent <= 1'b1;
            pwm    <= 1'b1;
        end else begin
            silent <= !play || release_gap || (note == REST);
            if (silent) begin
                pwm <= 1'b1;
            end else begin
                pwm <= !(per_cnt < (period >> 4));  // low for 1/16 of period
            end
        end
    end

    // any cause of silence reaches pwm two cycles later
    a_silent_high: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(!play || release_gap || (note == REST), 2) |-> pwm
    );

endmodule

`default_nettype wire

// File: rtl/score_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module score_sequencer
    import beep_note_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire key_t key,
    input  wire logic note_end,
    output logic      play,
    output note_t     note
);

    localparam score_idx_t LAST_IDX = score_idx_t'(SONG_LEN - 1);

    score_idx_t idx;

    // birthday song, four phrases
    function automatic note_t score_note(input score_idx_t i);
        case (i)
            5'd0:    score_note = SO;
            5'd1:    score_note = SO;
            5'd2:    score_note = LA;
            5'd3:    score_note = SO;
            5'd4:    score_note = DO;
            5'd5:    score_note = SI;
            5'd6:    score_note = REST;
            5'd7:    score_note = SO;
            5'd8:    score_note = SO;
            5'd9:    score_note = LA;
            5'd10:   score_note = SO;
            5'd11:   score_note = RE;
            5'd12:   score_note = DO;
            5'd13:   score_note = REST;
            5'd14:   score_note = SO;
            5'd15:   score_note = SO;
            5'd16:   score_note = SO;
            5'd17:   score_note = MI;
            5'd18:   score_note = DO;
            5'd19:   score_note = SI;
            5'd20:   score_note = LA;
            5'd21:   score_note = FA;
            5'd22:   score_note = FA;
            5'd23:   score_note = MI;
            5'd24:   score_note = DO;
            5'd25:   score_note = RE;
            5'd26:   score_note = DO;
            5'd27:   score_note = REST;
            default: score_note = REST;
        endcase
    endfunction

    assign play = (key == KEY_BIRTHDAY);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (!play) begin
            idx <= '0;          // key released, back to the top
        end else if (note_end) begin
            if (idx == LAST_IDX) begin
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            note <= REST;
        end else if (!play) begin
            note <= REST;
        end else begin
            note <= score_note(idx);
        end
    end

    a_idx_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        idx < SONG_LEN
    );

endmodule

`default_nettype wire

// File: rtl/note_timer.sv
`timescale 1ns/1ps
`default_nettype none

module note_timer
    import beep_timing_pkg::*;
#(
    parameter int NOTE_TICKS = 15_000_000
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic play,
    output logic      note_end,
    output logic      release_gap
);

    localparam tick_t LAST_TICK = tick_t'(NOTE_TICKS - 1);
    // silent for the last eighth of each note
    localparam tick_t GAP_START = tick_t'(NOTE_TICKS - NOTE_TICKS / 8);

    tick_t tick_cnt;

    assign note_end = play && (tick_cnt == LAST_TICK);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (!play) begin
            tick_cnt <= '0;
        end else if (note_end) begin
            tick_cnt <= '0;     // next note starts
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            release_gap <= 1'b0;
        end else begin
            release_gap <= play && (tick_cnt > GAP_START);
        end
    end

    // count wraps on note_end and never reaches the note length
    a_tick_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        play |=> tick_cnt < NOTE_TICKS
    );

    // gap is already up when the note ends
    a_gap_at_end: assert property (
        @(posedge clk) disable iff (!rst_n)
        note_end && $past(play) |-> release_gap
    );

endmodule

`default_nettype wire

// File: rtl/beep_timing_pkg.sv
`default_nettype none

package beep_timing_pkg;

    // longest tone period at 50 MHz is CLK_HZ / 523 = 95602 cycles
    localparam int PERIOD_W = 17;

    // 300 ms note at 50 MHz needs 15_000_000 ticks
    localparam int TICK_W = 25;

    typedef logic [PERIOD_W-1:0] period_t;
    typedef logic [TICK_W-1:0]   tick_t;

endpackage

`default_nettype wire

// File: rtl/beep_note_pkg.sv
`default_nettype none

package beep_note_pkg;

    // pitch codes, REST stays silent
    typedef enum logic [2:0] {
        REST = 3'd0,
        DO   = 3'd1,
        RE   = 3'd2,
        MI   = 3'd3,
        FA   = 3'd4,
        SO   = 3'd5,
        LA   = 3'd6,
        SI   = 3'd7
    } note_t;

    // pitch frequencies in Hz
    localparam int FREQ_DO = 523;
    localparam int FREQ_RE = 587;
    localparam int FREQ_MI = 659;
    localparam int FREQ_FA = 698;
    localparam int FREQ_SO = 784;
    localparam int FREQ_LA = 880;
    localparam int FREQ_SI = 988;

    localparam int SONG_LEN = 28;   // birthday song

    typedef logic [4:0] score_idx_t;

    // keys are active low
    typedef logic [2:0] key_t;

    localparam key_t KEY_BIRTHDAY = 3'b101;

endpackage

`default_nettype wire
